//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbSifh
FILELIST  ?= sifh.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASSMSG   ?= All checks passed

SRCS := $(wildcard *.sv)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status follows the pass message search
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

//--- histBinRam.sv
`timescale 1ns/1ps
`default_nettype none

module histBinRam (
    input  logic                           clk,
    input  logic                           rdEn,
    input  logic [sifhPkg::binBits-1:0]    rdAddr,
    output logic [sifhPkg::countBits-1:0]  rdData,
    input  logic                           wrEn,
    input  logic [sifhPkg::binBits-1:0]    wrAddr,
    input  logic [sifhPkg::countBits-1:0]  wrData
);

    // one count per bin
    logic [sifhPkg::countBits-1:0] mem [0:(1 << sifhPkg::binBits)-1];

    // simulation start value, later kept clean by the scan
    initial begin
        for (int i = 0; i < (1 << sifhPkg::binBits); i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same-address read and write returns the old count
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- histBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module histBuilder (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           hitValid,
    input  logic [sifhPkg::binBits-1:0]    hitBin,
    input  logic                           frameEnd,
    output logic                           busy,
    output logic                           peakValid,
    output logic [sifhPkg::binBits-1:0]    peakBin,
    output logic [sifhPkg::countBits-1:0]  peakCount,
    input  logic                           peakTaken
);

    // fsm
    logic [sifhPkg::stateBits-1:0] state;
    // second drain cycle
    logic drainCnt;
    // bin being read in scan
    logic [sifhPkg::binBits-1:0] scanAddr;

    // ram ports
    logic                          rdEn;
    logic [sifhPkg::binBits-1:0]   rdAddr;
    logic [sifhPkg::countBits-1:0] rdData;
    logic                          wrEn;
    logic [sifhPkg::binBits-1:0]   wrAddr;
    logic [sifhPkg::countBits-1:0] wrData;

    // stage 1, read issued last edge, data on rdData now
    logic                        s1Valid;
    logic                        s1Clear;
    logic [sifhPkg::binBits-1:0] s1Bin;

    // stage 2, copy of the write that retired at the last edge
    logic                          s2Valid;
    logic [sifhPkg::binBits-1:0]   s2Bin;
    logic [sifhPkg::countBits-1:0] s2Count;

    // increment path
    logic [sifhPkg::countBits-1:0] baseCount;
    logic [sifhPkg::countBits-1:0] incCount;
    // final compare of the scan this cycle
    logic lastBin;

    histBinRam binRam (
        .clk    (clk),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    // read side
    // hits read straight away, scan reads one bin per cycle
    always_comb begin
        rdEn   = 1'b0;
        rdAddr = hitBin;
        if (state == sifhPkg::stScan) begin
            rdEn   = 1'b1;
            rdAddr = scanAddr;
        end else if (state == sifhPkg::stCollect) begin
            rdEn = hitValid;
        end
    end

    // ram still shows the old count when the previous hit hit the same bin
    assign baseCount = (s2Valid && s2Bin == s1Bin) ? s2Count : rdData;

    // saturating +1
    assign incCount = (baseCount == sifhPkg::countMax) ? sifhPkg::countMax
                                                       : baseCount + 1'b1;

    // write side, one cycle behind the read
    assign wrEn   = s1Valid;
    assign wrAddr = s1Bin;
    // scan writes zero behind itself
    assign wrData = s1Clear ? '0 : incCount;

    assign lastBin = s1Valid && s1Clear && (int'(s1Bin) == sifhPkg::binNum - 1);

    assign busy = (state != sifhPkg::stCollect);

    // control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sifhPkg::stCollect;
            drainCnt  <= 1'b0;
            scanAddr  <= '0;
            peakValid <= 1'b0;
        end else begin
            case (state)
                sifhPkg::stCollect: begin
                    drainCnt <= 1'b0;
                    if (frameEnd) begin
                        state <= sifhPkg::stDrain;
                    end
                end
                sifhPkg::stDrain: begin
                    // two cycles, last hit is written in the first
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state <= sifhPkg::stScan;
                    end
                end
                sifhPkg::stScan: begin
                    // wraps back to bin 0 for the next frame
                    scanAddr <= scanAddr + 1'b1;
                    if (int'(scanAddr) == sifhPkg::binNum - 1) begin
                        state <= sifhPkg::stHold;
                    end
                end
                sifhPkg::stHold: begin
                    if (peakTaken) begin
                        state <= sifhPkg::stCollect;
                    end
                end
                default: begin
                    state <= sifhPkg::stCollect;
                end
            endcase

            // valid once the last bin went through the compare
            if (lastBin) begin
                peakValid <= 1'b1;
            end else if (state == sifhPkg::stHold && peakTaken) begin
                peakValid <= 1'b0;
            end
        end
    end

    // pipeline valids
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s1Clear <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= rdEn;
            s1Clear <= (state == sifhPkg::stScan);
            s2Valid <= wrEn;
        end
    end

    // pipeline payload and running maximum
    always_ff @(posedge clk) begin
        s1Bin   <= rdAddr;
        s2Bin   <= wrAddr;
        s2Count <= wrData;
        if (s1Valid && s1Clear) begin
            // bin 0 seeds the max
            // strict compare keeps the lower bin on a tie
            if (s1Bin == '0 || rdData > peakCount) begin
                peakBin   <= s1Bin;
                peakCount <= rdData;
            end
        end
    end

    // sensor side must stay quiet while a frame is processed
    hitWhileBusy: assert property (@(posedge clk) disable iff (!res)
        busy |-> !hitValid)
        else $error("hit received while busy");

    frameEndWhileBusy: assert property (@(posedge clk) disable iff (!res)
        busy |-> !frameEnd)
        else $error("frame end received while busy");

    // clear write trails the read by one bin
    scanCollision: assert property (@(posedge clk) disable iff (!res)
        (state == sifhPkg::stScan && wrEn) |-> (wrAddr != rdAddr))
        else $error("scan read and write on the same bin");

endmodule

`default_nettype wire

//--- peakCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module peakCombiner (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           peakValid0,
    input  logic                           peakValid1,
    input  logic [sifhPkg::binBits-1:0]    peakBin0,
    input  logic [sifhPkg::binBits-1:0]    peakBin1,
    input  logic [sifhPkg::countBits-1:0]  peakCount0,
    input  logic [sifhPkg::countBits-1:0]  peakCount1,
    output logic                           peakTaken,
    input  logic                           creditReturn,
    output logic                           resultValid,
    output logic                           resultPixel,
    output logic [sifhPkg::binBits-1:0]    resultBin,
    output logic [sifhPkg::countBits-1:0]  resultCount
);

    // credits left at the consumer
    logic [sifhPkg::creditBits-1:0] credits;
    // take the peaks this cycle
    logic issue;
    // pixel 1 strictly stronger
    logic pick1;

    // peakValid is still high in the peakTaken cycle
    assign issue = peakValid0 && peakValid1 && !peakTaken && (credits != '0);

    // tie goes to pixel 0
    assign pick1 = (peakCount1 > peakCount0);

    // credit counter
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            credits <= sifhPkg::creditMax[sifhPkg::creditBits-1:0];
        end else begin
            case ({issue, creditReturn})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                // issue and return cancel out
                default: credits <= credits;
            endcase
        end
    end

    // handshake pulses
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultValid <= 1'b0;
            peakTaken   <= 1'b0;
        end else begin
            resultValid <= issue;
            peakTaken   <= issue;
        end
    end

    // result word
    always_ff @(posedge clk) begin
        if (issue) begin
            resultPixel <= pick1;
            resultBin   <= pick1 ? peakBin1 : peakBin0;
            resultCount <= pick1 ? peakCount1 : peakCount0;
        end
    end

    // consumer returns no more than it was given
    creditOverflow: assert property (@(posedge clk) disable iff (!res)
        (creditReturn && !issue) |-> (int'(credits) < sifhPkg::creditMax))
        else $error("credit return beyond creditMax");

    // builders drop their peaks right after the take
    peakRelease: assert property (@(posedge clk) disable iff (!res)
        peakTaken |=> (!peakValid0 && !peakValid1))
        else $error("peak still valid after peakTaken");

endmodule

`default_nettype wire

//--- sifh.f
sifhPkg.sv
histBinRam.sv
histBuilder.sv
peakCombiner.sv
sifhTop.sv
tbSifh.sv

//--- sifhPkg.sv
`default_nettype none

package sifhPkg;

    // bin index width
    localparam int binBits = 6;

    // bins per pixel histogram
    localparam int binNum = 1 << binBits;

    // per-bin count width
    localparam int countBits = 8;

    // counts stick here instead of wrapping
    localparam logic [countBits-1:0] countMax = {countBits{1'b1}};

    // pixels served by one top level
    localparam int pixelNum = 2;

    // credits granted by the consumer out of reset
    localparam int creditMax = 2;

    // credit counter must hold 0 .. creditMax
    localparam int creditBits = $clog2(creditMax + 1);

    // histogram builder fsm encoding
    localparam int stateBits = 2;
    // normal hit accumulation
    localparam logic [stateBits-1:0] stCollect = 2'd0;
    // let the last hits retire
    localparam logic [stateBits-1:0] stDrain = 2'd1;
    // peak search with clear behind
    localparam logic [stateBits-1:0] stScan = 2'd2;
    // peak on display until taken
    localparam logic [stateBits-1:0] stHold = 2'd3;

endpackage

`default_nettype wire

//--- sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           hitValid0,
    input  logic [sifhPkg::binBits-1:0]    hitBin0,
    input  logic                           hitValid1,
    input  logic [sifhPkg::binBits-1:0]    hitBin1,
    input  logic                           frameEnd,
    output logic                           busy,
    input  logic                           creditReturn,
    output logic                           resultValid,
    output logic                           resultPixel,
    output logic [sifhPkg::binBits-1:0]    resultBin,
    output logic [sifhPkg::countBits-1:0]  resultCount
);

    // builder to combiner
    logic                          peakValid0;
    logic                          peakValid1;
    logic [sifhPkg::binBits-1:0]   peakBin0;
    logic [sifhPkg::binBits-1:0]   peakBin1;
    logic [sifhPkg::countBits-1:0] peakCount0;
    logic [sifhPkg::countBits-1:0] peakCount1;
    // one take for both
    logic                          peakTaken;

    // pixel 0 speaks for both
    histBuilder pixel0 (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid0),
        .hitBin    (hitBin0),
        .frameEnd  (frameEnd),
        .busy      (busy),
        .peakValid (peakValid0),
        .peakBin   (peakBin0),
        .peakCount (peakCount0),
        .peakTaken (peakTaken)
    );

    histBuilder pixel1 (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid1),
        .hitBin    (hitBin1),
        .frameEnd  (frameEnd),
        .busy      (),
        .peakValid (peakValid1),
        .peakBin   (peakBin1),
        .peakCount (peakCount1),
        .peakTaken (peakTaken)
    );

    peakCombiner combiner (
        .clk          (clk),
        .res          (res),
        .peakValid0   (peakValid0),
        .peakValid1   (peakValid1),
        .peakBin0     (peakBin0),
        .peakBin1     (peakBin1),
        .peakCount0   (peakCount0),
        .peakCount1   (peakCount1),
        .peakTaken    (peakTaken),
        .creditReturn (creditReturn),
        .resultValid  (resultValid),
        .resultPixel  (resultPixel),
        .resultBin    (resultBin),
        .resultCount  (resultCount)
    );

endmodule

`default_nettype wire

//--- tbSifh.sv
`timescale 1ns/1ps
`default_nettype none

module tbSifh;

    // result shows up about binNum + 4 cycles after frameEnd
    localparam int resultWait = sifhPkg::binNum + 16;
    localparam int busyWait = 8;
    // drain, scan, handshake, busy drop and credit return
    localparam int frameCycles = resultWait + busyWait + 4;
    // hit phases of all tests with random gaps at four cycles per hit pair
    localparam int hitCycles = 4 * 200 + 60 + 320 + 30 + 3 * 4 * 20;
    localparam int cycleLimit = 8 + 100 + 9 * frameCycles + 2 * resultWait + hitCycles + 500;

    logic clk = 1'b0;
    logic res;
    logic hitValid0;
    logic hitValid1;
    logic [sifhPkg::binBits-1:0] hitBin0;
    logic [sifhPkg::binBits-1:0] hitBin1;
    logic frameEnd;
    logic busy;
    logic creditReturn;
    logic resultValid;
    logic resultPixel;
    logic [sifhPkg::binBits-1:0] resultBin;
    logic [sifhPkg::countBits-1:0] resultCount;

    int valueErrors = 0;
    int otherErrors = 0;
    int cycles = 0;
    logic [31:0] lfsr = 32'hbbed;
    // reference histograms
    int model [sifhPkg::pixelNum][sifhPkg::binNum];
    // expected and last seen result word
    logic expPixel;
    logic [sifhPkg::binBits-1:0] expBin;
    logic [sifhPkg::countBits-1:0] expCount;
    logic lastPixel;
    logic [sifhPkg::countBits-1:0] lastCount;

    sifhTop dut (
        .clk          (clk),
        .res          (res),
        .hitValid0    (hitValid0),
        .hitBin0      (hitBin0),
        .hitValid1    (hitValid1),
        .hitBin1      (hitBin1),
        .frameEnd     (frameEnd),
        .busy         (busy),
        .creditReturn (creditReturn),
        .resultValid  (resultValid),
        .resultPixel  (resultPixel),
        .resultBin    (resultBin),
        .resultCount  (resultCount)
    );

    always #4 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [sifhPkg::binBits-1:0] randBin();
        logic [sifhPkg::binBits-1:0] v;
        v = '0;
        for (int i = 0; i < sifhPkg::binBits; i++) begin
            v = {v[sifhPkg::binBits-2:0], lfsrBit()};
        end
        return v;
    endfunction

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valueErrors++;
            $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic checkBin(input string name, input logic [sifhPkg::binBits-1:0] exp,
                            input logic [sifhPkg::binBits-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input logic [sifhPkg::countBits-1:0] exp,
                              input logic [sifhPkg::countBits-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // one cycle of hits with the model following under saturation
    task automatic driveHits(input logic v0, input logic [sifhPkg::binBits-1:0] b0,
                             input logic v1, input logic [sifhPkg::binBits-1:0] b1);
        @(negedge clk);
        hitValid0 = v0;
        hitBin0 = b0;
        hitValid1 = v1;
        hitBin1 = b1;
        if (v0 && model[0][b0] < int'(sifhPkg::countMax)) begin
            model[0][b0]++;
        end
        if (v1 && model[1][b1] < int'(sifhPkg::countMax)) begin
            model[1][b1]++;
        end
    endtask

    task automatic randomHits(input int count);
        int sent0;
        int sent1;
        logic v0;
        logic v1;
        logic [sifhPkg::binBits-1:0] b0;
        logic [sifhPkg::binBits-1:0] b1;
        sent0 = 0;
        sent1 = 0;
        while (sent0 < count || sent1 < count) begin
            // a zero bit leaves a gap
            v0 = (sent0 < count) && lfsrBit();
            v1 = (sent1 < count) && lfsrBit();
            b0 = v0 ? randBin() : '0;
            b1 = v1 ? randBin() : '0;
            driveHits(v0, b0, v1, b1);
            sent0 = sent0 + int'(v0);
            sent1 = sent1 + int'(v1);
        end
    endtask

    // expected word from the model before the model is cleared like the scan
    task automatic endFrame();
        int peakCnt [sifhPkg::pixelNum];
        int peakIdx [sifhPkg::pixelNum];
        int pick;
        for (int p = 0; p < sifhPkg::pixelNum; p++) begin
            peakCnt[p] = model[p][0];
            peakIdx[p] = 0;
            for (int b = 1; b < sifhPkg::binNum; b++) begin
                // lower bin keeps a tie
                if (model[p][b] > peakCnt[p]) begin
                    peakCnt[p] = model[p][b];
                    peakIdx[p] = b;
                end
                model[p][b] = 0;
            end
            model[p][0] = 0;
        end
        // pixel 0 keeps a tie
        pick = (peakCnt[1] > peakCnt[0]) ? 1 : 0;
        expPixel = (pick == 1);
        expBin = peakIdx[pick][sifhPkg::binBits-1:0];
        expCount = peakCnt[pick][sifhPkg::countBits-1:0];
        @(negedge clk);
        hitValid0 = 1'b0;
        hitValid1 = 1'b0;
        frameEnd = 1'b1;
        @(negedge clk);
        frameEnd = 1'b0;
    endtask

    task automatic checkResult(input string name);
        logic found;
        found = 1'b0;
        for (int i = 0; i < resultWait && !found; i++) begin
            @(negedge clk);
            found = resultValid;
        end
        if (!found) begin
            otherErrors++;
            $display("no result word arrived for %s within %0d cycles", name, resultWait);
        end else begin
            checkBit({name, " pixel"}, expPixel, resultPixel);
            checkBin({name, " bin"}, expBin, resultBin);
            checkCount({name, " count"}, expCount, resultCount);
            lastPixel = resultPixel;
            lastCount = resultCount;
        end
    endtask

    task automatic waitBusyLow(input string name);
        for (int i = 0; i < busyWait && busy; i++) begin
            @(negedge clk);
        end
        if (busy) begin
            otherErrors++;
            $display("busy stayed high after the result of %s", name);
        end
    endtask

    task automatic returnCredit();
        @(negedge clk);
        creditReturn = 1'b1;
        @(negedge clk);
        creditReturn = 1'b0;
    endtask

    // frame with credit handed straight back
    task automatic runFrame(input string name);
        endFrame();
        checkResult(name);
        waitBusyLow(name);
        returnCredit();
    endtask

    task automatic testReset();
        @(negedge clk);
        checkBit("reset resultValid", 1'b0, resultValid);
        checkBit("reset busy", 1'b0, busy);
        repeat (100) begin
            @(negedge clk);
            checkBit("idle resultValid", 1'b0, resultValid);
        end
    endtask

    task automatic testRandom();
        randomHits(200);
        runFrame("random histogram");
    endtask

    // same-bin runs hit the forwarding path while alternating bins miss it
    task automatic testForwarding();
        for (int i = 0; i < 8; i++) begin
            driveHits(1'b1, (i % 2) ? 6'd4 : 6'd3, 1'b1, (i % 2) ? 6'd41 : 6'd40);
        end
        for (int i = 0; i < 9; i++) begin
            driveHits(i < 6, 6'd12, 1'b1, 6'd50);
        end
        for (int i = 0; i < 2; i++) begin
            driveHits(1'b1, (i % 2) ? 6'd4 : 6'd3, 1'b1, (i % 2) ? 6'd41 : 6'd40);
        end
        runFrame("forwarding pixel 1");
        checkCount("forwarding run length 9", 8'd9, lastCount);
        for (int i = 0; i < 10; i++) begin
            driveHits(1'b1, 6'd63, i < 4, (i % 2) ? 6'd1 : 6'd2);
        end
        runFrame("forwarding pixel 0");
        checkCount("forwarding run length 10", 8'd10, lastCount);
    endtask

    task automatic testSaturation();
        for (int i = 0; i < 300; i++) begin
            driveHits(1'b1, 6'd17, i < 10, 6'd5);
        end
        runFrame("saturation");
        checkCount("saturated count", sifhPkg::countMax, lastCount);
        // counts restart from zero after the clearing scan
        for (int i = 0; i < 4; i++) begin
            driveHits(1'b1, (i < 3) ? 6'd17 : 6'd2, i < 2, 6'd5);
        end
        runFrame("cleared histogram");
        checkCount("count after clear", 8'd3, lastCount);
    endtask

    task automatic testTie();
        for (int i = 0; i < 10; i++) begin
            driveHits(1'b1, (i < 5) ? 6'd30 : 6'd50, i < 5, 6'd10);
        end
        runFrame("pixel tie");
        checkBit("tie goes to pixel 0", 1'b0, lastPixel);
        for (int i = 0; i < 6; i++) begin
            driveHits(i < 5, 6'd30, 1'b1, 6'd10);
        end
        runFrame("pixel 1 ahead");
        checkBit("stronger pixel 1", 1'b1, lastPixel);
    endtask

    task automatic testCredit();
        // two frames spend both credits
        for (int f = 0; f < 2; f++) begin
            randomHits(20);
            endFrame();
            checkResult("credit frame");
            waitBusyLow("credit frame");
        end
        randomHits(20);
        endFrame();
        // third result waits with busy held
        for (int i = 0; i < 2 * resultWait; i++) begin
            @(negedge clk);
            checkBit("held resultValid", 1'b0, resultValid);
            checkBit("held busy", 1'b1, busy);
        end
        returnCredit();
        checkResult("released frame");
        waitBusyLow("released frame");
        returnCredit();
        returnCredit();
    endtask

    initial begin
        res = 1'b0;
        hitValid0 = 1'b0;
        hitValid1 = 1'b0;
        hitBin0 = '0;
        hitBin1 = '0;
        frameEnd = 1'b0;
        creditReturn = 1'b0;
        repeat (8) @(negedge clk);
        res = 1'b1;
        testReset();
        testRandom();
        testForwarding();
        testSaturation();
        testTie();
        testCredit();
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
